//--- dv/backplane_tb.sv
`timescale 1ns/100ps

// Drive backplane testbench
// Bit-bangs I2C against the top level and checks register reads, power
// enables and LED patterns against a shadow register model

module backplane_tb;

	localparam logic [6:0] own_addr     = 7'h40;
	localparam logic [6:0] foreign_addr = 7'h41;
	localparam int tick_cycles  = 16;
	localparam int heart_period = 8 * tick_cycles;
	localparam int half_cycles  = 10;
	localparam int bit_cycles   = 2 * half_cycles;
	// Longest transfer is 24 data bytes behind three address bytes
	localparam int xfer_cycles  = (27 * 9 + 4) * bit_cycles;
	// Transfers per test, in test order
	localparam int xfer_count   = 1 + 40 + 1 + 2 + 4 + 1;
	localparam int timeout_cycles = xfer_count * xfer_cycles + 4 * heart_period + 1000;

	logic        sysclk = 1'b0;
	logic        reset;
	logic        scl;
	logic        sda_low;
	wire         sda;
	logic        sda_pull;
	logic [14:0] drive_present_l;
	logic [14:0] p5v_good;
	logic [14:0] p12v_good;
	logic [14:0] pwr_en_l;
	logic [14:0] health_led;
	logic [14:0] fault_led;
	logic        heart;

	logic [7:0] shadow [256];
	logic [7:0] wr_q[$];
	logic [7:0] rd_q[$];
	logic [3:0] nib_q[$];
	logic [3:0] led_mode_q[$];
	int         test_errors  = 0;
	int         test_checks  = 0;
	int         total_errors = 0;
	int         total_checks = 0;
	int         test_count   = 0;
	int         cycle_count  = 0;
	int         pull_cycles  = 0;

	// Open-drain bus, low when either side pulls
	assign sda = ~(sda_low | sda_pull);

	always #5 sysclk = ~sysclk;

	always @(posedge sysclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	always @(posedge sysclk) begin
		if (sda_pull)
			pull_cycles <= pull_cycles + 1;
	end

	backplane_top #(
		.i2c_addr    (own_addr),
		.tick_cycles (tick_cycles)
	) backplane_top_inst (
		.sysclk          (sysclk),
		.reset           (reset),
		.scl             (scl),
		.sda_in          (sda),
		.sda_pull        (sda_pull),
		.drive_present_l (drive_present_l),
		.p5v_good        (p5v_good),
		.p12v_good       (p12v_good),
		.pwr_en_l        (pwr_en_l),
		.health_led      (health_led),
		.fault_led       (fault_led),
		.heart           (heart)
	);

	// ************************************************************
	// Checks and reporting
	// ************************************************************

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		test_checks++;
		total_checks++;
		assert (got == want) else begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, want);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic require(input logic cond, input string what);
		test_checks++;
		total_checks++;
		assert (cond) else begin
			$display("Check failed: %s", what);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic start_test();
		test_errors = 0;
		test_checks = 0;
	endtask

	task automatic report_test(input string name);
		test_count++;
		$display("Test %0d (%s): %0d checks, %0d errors", test_count, name, test_checks,
			test_errors);
	endtask

	function automatic string led_name(input int k);
		if (k < 15)
			return $sformatf("health_led[%0d]", k);
		else
			return $sformatf("fault_led[%0d]", k - 15);
	endfunction

	// ************************************************************
	// Shadow register model
	// ************************************************************

	function automatic void reset_shadow();
		for (int a = 0; a < 256; a++)
			shadow[8'(a)] = 8'h00;
		// All bays unpowered
		shadow[8'h10] = 8'hFF;
		shadow[8'h11] = 8'hFF;
		// Low nibble on, high nibble off
		for (int a = 0; a < 8; a++) begin
			shadow[8'h20 + 8'(a)] = 8'h01;
			shadow[8'h30 + 8'(a)] = 8'h01;
		end
		shadow[8'hF0] = 8'h01;
		shadow[8'hF1] = 8'h00;
	endfunction

	function automatic void update_shadow(input logic [7:0] addr, input logic [7:0] data);
		if (addr == 8'h10 || addr == 8'h11 || (addr >= 8'h20 && addr <= 8'h27) ||
				(addr >= 8'h30 && addr <= 8'h37))
			shadow[addr] = data;
	endfunction

	function automatic logic [7:0] expected_read(input logic [7:0] addr);
		case (addr)
			8'h00:   return drive_present_l[7:0];
			8'h01:   return {1'b0, drive_present_l[14:8]};
			8'h02:   return p5v_good[7:0];
			8'h03:   return {1'b0, p5v_good[14:8]};
			8'h04:   return p12v_good[7:0];
			8'h05:   return {1'b0, p12v_good[14:8]};
			default: return shadow[addr];
		endcase
	endfunction

	// Bit 7 of 11h has no pin
	function automatic logic [14:0] expected_pwr_en();
		return {shadow[8'h11][6:0], shadow[8'h10]};
	endfunction

	// ************************************************************
	// I2C master
	// ************************************************************

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sysclk);
		#1;
	endtask

	// Starts and ends with SCL just gone low
	task automatic clock_bit(input logic out_bit, output logic in_bit);
		wait_cycles(half_cycles / 2);
		sda_low = ~out_bit;
		wait_cycles(half_cycles / 2);
		scl = 1'b1;
		wait_cycles(half_cycles / 2);
		in_bit = sda;
		wait_cycles(half_cycles / 2);
		scl = 1'b0;
	endtask

	// Also a repeated start when SCL is low
	task automatic issue_start();
		if (scl == 1'b0) begin
			wait_cycles(half_cycles / 2);
			sda_low = 1'b0;
			wait_cycles(half_cycles / 2);
			scl = 1'b1;
			wait_cycles(half_cycles);
		end
		sda_low = 1'b1;
		wait_cycles(half_cycles);
		scl = 1'b0;
	endtask

	task automatic issue_stop();
		wait_cycles(half_cycles / 2);
		sda_low = 1'b1;
		wait_cycles(half_cycles / 2);
		scl = 1'b1;
		wait_cycles(half_cycles);
		sda_low = 1'b0;
		wait_cycles(half_cycles);
	endtask

	task automatic send_byte(input logic [7:0] data, output logic acked);
		logic [7:0] d;
		logic       b;
		d = data;
		for (int i = 0; i < 8; i++) begin
			clock_bit(d[7], b);
			d = {d[6:0], 1'b0};
		end
		clock_bit(1'b1, b);
		acked = ~b;
	endtask

	// A released ACK bit is a NACK
	task automatic receive_byte(input logic last, output logic [7:0] data);
		logic [7:0] d;
		logic       b;
		d = '0;
		for (int i = 0; i < 8; i++) begin
			clock_bit(1'b1, b);
			d = {d[6:0], b};
		end
		clock_bit(last, b);
		data = d;
	endtask

	// Pointer byte, then the bytes in wr_q
	task automatic write_regs(input logic [6:0] dev, input logic [7:0] ptr, output logic acked);
		logic       a;
		logic       ok;
		logic [7:0] addr;
		issue_start();
		send_byte({dev, 1'b0}, a);
		ok = a;
		if (a) begin
			send_byte(ptr, a);
			ok = ok & a;
			addr = ptr;
			for (int i = 0; i < wr_q.size(); i++) begin
				send_byte(wr_q[i], a);
				ok = ok & a;
				if (a)
					update_shadow(addr, wr_q[i]);
				addr = addr + 8'd1;
			end
		end
		issue_stop();
		acked = ok;
	endtask

	task automatic read_regs(input logic [7:0] ptr, input int count, output logic acked);
		logic       a;
		logic       ok;
		logic [7:0] d;
		rd_q.delete();
		issue_start();
		send_byte({own_addr, 1'b0}, a);
		ok = a;
		send_byte(ptr, a);
		ok = ok & a;
		issue_start();
		send_byte({own_addr, 1'b1}, a);
		ok = ok & a;
		for (int i = 0; i < count; i++) begin
			receive_byte(i == count - 1, d);
			rd_q.push_back(d);
		end
		issue_stop();
		acked = ok;
	endtask

	task automatic read_and_check(input logic [7:0] ptr, input int count);
		logic acked;
		read_regs(ptr, count, acked);
		require(acked, $sformatf("read from 0x%02h was not acknowledged", ptr));
		for (int i = 0; i < rd_q.size(); i++)
			compare_value($sformatf("read byte reg[%02h]", ptr + 8'(i)), 32'(rd_q[i]),
				32'(expected_read(ptr + 8'(i))));
	endtask

	// ************************************************************
	// LED window, two heart periods
	// ************************************************************

	// LED outputs lag the phase by one cycle, so compare with last cycle's heart
	task automatic verify_led_window();
		logic [29:0] leds;
		logic [29:0] prev_leds;
		logic        prev_heart;
		logic        cur;
		logic        prev;
		logic [3:0]  mode;
		int          edge_cnt[$];
		int          heart_edges;
		int          heart_high;
		edge_cnt.delete();
		for (int k = 0; k < 30; k++)
			edge_cnt.push_back(0);
		heart_edges = 0;
		heart_high = 0;
		prev_leds = {fault_led, health_led};
		prev_heart = heart;
		for (int n = 0; n < 2 * heart_period; n++) begin
			wait_cycles(1);
			leds = {fault_led, health_led};
			for (int k = 0; k < 30; k++) begin
				mode = led_mode_q[k];
				cur = 1'(leds >> k);
				prev = 1'(prev_leds >> k);
				case (mode)
					4'd1:       compare_value(led_name(k), 32'(cur), 32'd1);
					4'd2:       compare_value(led_name(k), 32'(cur), 32'(prev_heart));
					4'd3, 4'd4: begin
						if (cur && !prev)
							edge_cnt[k] = edge_cnt[k] + 1;
					end
					// Off and unknown codes
					default:    compare_value(led_name(k), 32'(cur), 32'd0);
				endcase
			end
			// Heart is a 1 Hz square wave, half of the window high
			if (heart && !prev_heart)
				heart_edges++;
			if (heart)
				heart_high++;
			prev_leds = leds;
			prev_heart = heart;
		end
		compare_value("heart rising edges", 32'(heart_edges), 32'd2);
		compare_value("heart high cycles", 32'(heart_high), 32'(heart_period));
		for (int k = 0; k < 30; k++) begin
			if (led_mode_q[k] == 4'd3)
				compare_value({led_name(k), " rising edges"}, 32'(edge_cnt[k]), 32'd4);
			else if (led_mode_q[k] == 4'd4)
				compare_value({led_name(k), " rising edges"}, 32'(edge_cnt[k]), 32'd8);
		end
	endtask

	// ************************************************************
	// Test sequence
	// ************************************************************

	initial begin
		int unsigned seed_val;
		logic        acked;
		logic [7:0]  addr;
		int          pulls_before;

		seed_val = $urandom(34);
		reset = 1'b1;
		scl = 1'b1;
		sda_low = 1'b0;
		drive_present_l = '1;
		p5v_good = '0;
		p12v_good = '0;
		reset_shadow();
		repeat (16) @(posedge sysclk);
		#1;
		reset = 1'b0;
		wait_cycles(4);

		start_test();
		compare_value("pwr_en_l", 32'(pwr_en_l), 32'(expected_pwr_en()));
		// Blink phase starts at zero, bus released
		compare_value("heart", 32'(heart), 32'h0);
		compare_value("sda_pull", 32'(sda_pull), 32'h0);
		read_and_check(8'hF0, 2);
		// Even drives lit, odd drives dark
		compare_value("health_led", 32'(health_led), 32'h5555);
		compare_value("fault_led", 32'(fault_led), 32'h5555);
		report_test("reset state");

		start_test();
		for (int n = 0; n < 20; n++) begin
			wr_q.delete();
			wr_q.push_back(8'($urandom));
			wr_q.push_back(8'($urandom));
			write_regs(own_addr, 8'h10, acked);
			require(acked, "power enable write was not acknowledged");
			compare_value("pwr_en_l", 32'(pwr_en_l), 32'(expected_pwr_en()));
			read_and_check(8'h10, 2);
		end
		report_test("power enables");

		start_test();
		drive_present_l = 15'($urandom);
		p5v_good = 15'($urandom);
		p12v_good = 15'($urandom);
		wait_cycles(4);
		read_and_check(8'h00, 6);
		report_test("drive status");

		start_test();
		nib_q.delete();
		for (int i = 0; i < 32; i++)
			nib_q.push_back(4'($urandom_range(0, 7)));
		// 20h-27h health, 28h-2Fh unmapped filler, 30h-37h fault
		wr_q.delete();
		for (int i = 0; i < 24; i++) begin
			if (i < 8)
				wr_q.push_back({nib_q[2*i+1], nib_q[2*i]});
			else if (i < 16)
				wr_q.push_back(8'($urandom));
			else
				wr_q.push_back({nib_q[2*i-15], nib_q[2*i-16]});
		end
		write_regs(own_addr, 8'h20, acked);
		require(acked, "LED mode write was not acknowledged");
		read_and_check(8'h20, 24);
		led_mode_q.delete();
		for (int d = 0; d < 15; d++)
			led_mode_q.push_back(nib_q[d]);
		for (int d = 0; d < 15; d++)
			led_mode_q.push_back(nib_q[16+d]);
		verify_led_window();
		report_test("LED modes");

		start_test();
		wr_q.delete();
		for (int i = 0; i < 6; i++)
			wr_q.push_back(8'($urandom));
		write_regs(own_addr, 8'h00, acked);
		require(acked, "status write was not acknowledged");
		read_and_check(8'h00, 6);
		addr = 8'h60 + 8'($urandom_range(0, 31));
		wr_q.delete();
		wr_q.push_back(8'($urandom_range(1, 255)));
		write_regs(own_addr, addr, acked);
		require(acked, "unmapped write was not acknowledged");
		read_and_check(addr, 1);
		compare_value("unmapped read", 32'(rd_q[0]), 32'h00);
		compare_value("pwr_en_l", 32'(pwr_en_l), 32'(expected_pwr_en()));
		report_test("read-only and unmapped");

		start_test();
		pulls_before = pull_cycles;
		wr_q.delete();
		wr_q.push_back(8'h00);
		write_regs(foreign_addr, 8'h10, acked);
		require(!acked, "target acknowledged another device address");
		compare_value("sda_pull cycles", 32'(pull_cycles - pulls_before), 32'h0);
		compare_value("pwr_en_l", 32'(pwr_en_l), 32'(expected_pwr_en()));
		report_test("foreign address");

		$display("Tests: %0d, checks: %0d, errors: %0d", test_count, total_checks, total_errors);
		if (total_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- project.f
src/bp_reg_pkg.sv
src/bp_led_pkg.sv
src/drive_status_sync.sv
src/i2c_target.sv
src/backplane_regs.sv
src/blink_timebase.sv
src/led_pattern.sv
src/backplane_top.sv
dv/backplane_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the backplane testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module backplane_tb \
	-Mdir obj_dir -o sim_backplane
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_backplane > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
exit 0

//--- src/backplane_regs.sv
`timescale 1ns/100ps

// Backplane register file
// Decodes the register pointer, holds power enable and LED mode bytes,
// and returns registered read data for the I2C engine.

module backplane_regs (
	input  logic                                sysclk,
	input  logic                                reset,
	input  bp_reg_pkg::reg_addr_t               reg_addr,
	input  bp_reg_pkg::reg_data_t               wr_data,
	input  logic                                wr_strobe,
	input  logic                                rd_strobe,
	output bp_reg_pkg::reg_data_t               rd_data,
	input  logic [bp_reg_pkg::num_drives-1:0]   present_l_sync,
	input  logic [bp_reg_pkg::num_drives-1:0]   p5v_sync,
	input  logic [bp_reg_pkg::num_drives-1:0]   p12v_sync,
	output logic [bp_reg_pkg::num_drives-1:0]   pwr_en_l,
	output logic [4*bp_reg_pkg::num_drives-1:0] health_modes,
	output logic [4*bp_reg_pkg::num_drives-1:0] fault_modes
);
	import bp_reg_pkg::*;

	logic [15:0] pwr_en_q;
	logic [63:0] health_q;
	logic [63:0] fault_q;
	logic        sel_pwr;
	logic        sel_health;
	logic        sel_fault;
	reg_data_t   rd_mux;

	// *********************************************************
	// Address decode
	// *********************************************************

	assign sel_pwr    = (reg_addr[7:1] == addr_pwr_en_base[7:1]);
	assign sel_health = (reg_addr[7:3] == addr_health_base[7:3]);
	assign sel_fault  = (reg_addr[7:3] == addr_fault_base[7:3]);

	// *********************************************************
	// Writable ports
	// *********************************************************

	always_ff @(posedge sysclk) begin
		if (reset) begin
			pwr_en_q <= {2{pwr_en_reset}};
			health_q <= {8{led_reg_reset}};
			fault_q  <= {8{led_reg_reset}};
		end else if (wr_strobe) begin
			// Status, version and unmapped addresses take no writes
			if (sel_pwr)
				pwr_en_q[{reg_addr[0], 3'b000} +: 8] <= wr_data;
			if (sel_health)
				health_q[{reg_addr[2:0], 3'b000} +: 8] <= wr_data;
			if (sel_fault)
				fault_q[{reg_addr[2:0], 3'b000} +: 8] <= wr_data;
		end
	end

	// Pin flop on the enables, bit 15 stays internal
	always_ff @(posedge sysclk) begin
		if (reset)
			pwr_en_l <= '1;
		else
			pwr_en_l <= pwr_en_q[num_drives-1:0];
	end

	assign health_modes = health_q[4*num_drives-1:0];
	assign fault_modes  = fault_q[4*num_drives-1:0];

	// *********************************************************
	// Read mux
	// *********************************************************

	always_comb begin
		rd_mux = '0;
		if (sel_pwr) begin
			rd_mux = pwr_en_q[{reg_addr[0], 3'b000} +: 8];
		end else if (sel_health) begin
			rd_mux = health_q[{reg_addr[2:0], 3'b000} +: 8];
		end else if (sel_fault) begin
			rd_mux = fault_q[{reg_addr[2:0], 3'b000} +: 8];
		end else begin
			case (reg_addr)
				addr_status_base:         rd_mux = present_l_sync[7:0];
				addr_status_base + 8'd1:  rd_mux = {1'b0, present_l_sync[num_drives-1:8]};
				addr_status_base + 8'd2:  rd_mux = p5v_sync[7:0];
				addr_status_base + 8'd3:  rd_mux = {1'b0, p5v_sync[num_drives-1:8]};
				addr_status_base + 8'd4:  rd_mux = p12v_sync[7:0];
				addr_status_base + 8'd5:  rd_mux = {1'b0, p12v_sync[num_drives-1:8]};
				addr_version_base:        rd_mux = version_major;
				addr_version_base + 8'd1: rd_mux = version_minor;
				default:                  rd_mux = '0;
			endcase
		end
	end

	always_ff @(posedge sysclk) begin
		if (rd_strobe)
			rd_data <= rd_mux;
	end

endmodule

//--- src/backplane_top.sv
`timescale 1ns/100ps

// Drive backplane management top level
// I2C register access to drive status, power enables and LED modes,
// plus the blink time base and heartbeat

module backplane_top #(
	parameter logic [6:0] i2c_addr    = 7'h40,
	parameter int         tick_cycles = 6_250_000
) (
	input  logic                              sysclk,
	input  logic                              reset,
	input  logic                              scl,
	input  logic                              sda_in,
	output logic                              sda_pull,
	input  logic [bp_reg_pkg::num_drives-1:0] drive_present_l,
	input  logic [bp_reg_pkg::num_drives-1:0] p5v_good,
	input  logic [bp_reg_pkg::num_drives-1:0] p12v_good,
	output logic [bp_reg_pkg::num_drives-1:0] pwr_en_l,
	output logic [bp_reg_pkg::num_drives-1:0] health_led,
	output logic [bp_reg_pkg::num_drives-1:0] fault_led,
	output logic                              heart
);
	import bp_reg_pkg::*;
	import bp_led_pkg::*;

	logic [num_drives-1:0]   present_l_sync;
	logic [num_drives-1:0]   p5v_sync;
	logic [num_drives-1:0]   p12v_sync;
	reg_addr_t               reg_addr;
	reg_data_t               wr_data;
	reg_data_t               rd_data;
	logic                    wr_strobe;
	logic                    rd_strobe;
	logic [4*num_drives-1:0] health_modes;
	logic [4*num_drives-1:0] fault_modes;
	blink_phase_t            blink_phase;

	// *********************************************************
	// Host access path
	// *********************************************************

	drive_status_sync drive_status_sync_inst (
		.sysclk          (sysclk),
		.reset           (reset),
		.drive_present_l (drive_present_l),
		.p5v_good        (p5v_good),
		.p12v_good       (p12v_good),
		.present_l_sync  (present_l_sync),
		.p5v_sync        (p5v_sync),
		.p12v_sync       (p12v_sync)
	);

	i2c_target #(
		.i2c_addr (i2c_addr)
	) i2c_target_inst (
		.sysclk    (sysclk),
		.reset     (reset),
		.scl       (scl),
		.sda_in    (sda_in),
		.sda_pull  (sda_pull),
		.reg_addr  (reg_addr),
		.wr_data   (wr_data),
		.wr_strobe (wr_strobe),
		.rd_strobe (rd_strobe),
		.rd_data   (rd_data)
	);

	backplane_regs backplane_regs_inst (
		.sysclk         (sysclk),
		.reset          (reset),
		.reg_addr       (reg_addr),
		.wr_data        (wr_data),
		.wr_strobe      (wr_strobe),
		.rd_strobe      (rd_strobe),
		.rd_data        (rd_data),
		.present_l_sync (present_l_sync),
		.p5v_sync       (p5v_sync),
		.p12v_sync      (p12v_sync),
		.pwr_en_l       (pwr_en_l),
		.health_modes   (health_modes),
		.fault_modes    (fault_modes)
	);

	// *********************************************************
	// LED drive
	// *********************************************************

	blink_timebase #(
		.tick_cycles (tick_cycles)
	) blink_timebase_inst (
		.sysclk      (sysclk),
		.reset       (reset),
		.blink_phase (blink_phase),
		.heart       (heart)
	);

	led_pattern led_pattern_inst (
		.sysclk       (sysclk),
		.reset        (reset),
		.health_modes (health_modes),
		.fault_modes  (fault_modes),
		.blink_phase  (blink_phase),
		.health_led   (health_led),
		.fault_led    (fault_led)
	);

endmodule

//--- src/blink_timebase.sv
`timescale 1ns/100ps

// Blink time base
// Eighth-second prescaler feeding a 3-bit phase counter, which gives
// the 4/2/1 Hz blink waves and the heartbeat

module blink_timebase #(
	parameter int tick_cycles = 6_250_000
) (
	input  logic                     sysclk,
	input  logic                     reset,
	output bp_led_pkg::blink_phase_t blink_phase,
	output logic                     heart
);
	import bp_led_pkg::*;

	localparam int pre_w = $clog2(tick_cycles + 1);

	logic [pre_w-1:0] pre_cnt;
	logic             tick;

	assign tick = (pre_cnt == pre_w'(tick_cycles - 1));

	always_ff @(posedge sysclk) begin
		if (reset) begin
			pre_cnt     <= '0;
			blink_phase <= '0;
		end else begin
			pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
			// Wraps every second
			if (tick)
				blink_phase <= blink_phase + 3'd1;
		end
	end

	assign heart = blink_phase[phase_1hz_bit];

endmodule

//--- src/bp_led_pkg.sv
// Drive LED definitions
// Mode codes held in the LED registers and the blink phase layout

package bp_led_pkg;

	// Codes not listed here show as off
	typedef enum logic [3:0] {
		led_off       = 4'd0,
		led_on        = 4'd1,
		led_blink_1hz = 4'd2,
		led_blink_2hz = 4'd3,
		led_blink_4hz = 4'd4
	} led_mode_e;

	// Three square waves from one eighth-second counter
	typedef logic [2:0] blink_phase_t;

	localparam int phase_4hz_bit = 0;
	localparam int phase_2hz_bit = 1;
	localparam int phase_1hz_bit = 2;

endpackage

//--- src/bp_reg_pkg.sv
// Backplane register map
// Port addresses, reset values and field widths seen by the I2C host

package bp_reg_pkg;

	// *********************************************************
	// Widths
	// *********************************************************

	// Drive bays on the backplane
	localparam int num_drives = 15;

	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// *********************************************************
	// Port base addresses
	// *********************************************************

	// Presence, 5V good and 12V good, two bytes each
	localparam reg_addr_t addr_status_base  = 8'h00;
	localparam reg_addr_t addr_pwr_en_base  = 8'h10;
	// Eight bytes each, two drives per byte
	localparam reg_addr_t addr_health_base  = 8'h20;
	localparam reg_addr_t addr_fault_base   = 8'h30;
	localparam reg_addr_t addr_version_base = 8'hF0;

	// *********************************************************
	// Reset values
	// *********************************************************

	// Enables are active low, so all bays start unpowered
	localparam reg_data_t pwr_en_reset  = 8'hFF;
	// Even drive on, odd drive off
	localparam reg_data_t led_reg_reset = 8'h01;

	// Version header
	localparam reg_data_t version_major = 8'h01;
	localparam reg_data_t version_minor = 8'h00;

endpackage

//--- src/drive_status_sync.sv
`timescale 1ns/100ps

// Drive status synchronizer
// Two flops per presence and power-good input before the register file

module drive_status_sync (
	input  logic                              sysclk,
	input  logic                              reset,
	input  logic [bp_reg_pkg::num_drives-1:0] drive_present_l,
	input  logic [bp_reg_pkg::num_drives-1:0] p5v_good,
	input  logic [bp_reg_pkg::num_drives-1:0] p12v_good,
	output logic [bp_reg_pkg::num_drives-1:0] present_l_sync,
	output logic [bp_reg_pkg::num_drives-1:0] p5v_sync,
	output logic [bp_reg_pkg::num_drives-1:0] p12v_sync
);
	import bp_reg_pkg::*;

	localparam int chain_w = 3 * num_drives;
	// Empty bays, no power good
	localparam logic [chain_w-1:0] chain_reset = {{num_drives{1'b1}}, {2*num_drives{1'b0}}};

	logic [chain_w-1:0] meta_q;
	logic [chain_w-1:0] sync_q;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			meta_q <= chain_reset;
			sync_q <= chain_reset;
		end else begin
			meta_q <= {drive_present_l, p5v_good, p12v_good};
			sync_q <= meta_q;
		end
	end

	assign present_l_sync = sync_q[3*num_drives-1:2*num_drives];
	assign p5v_sync       = sync_q[2*num_drives-1:num_drives];
	assign p12v_sync      = sync_q[num_drives-1:0];

endmodule

//--- src/i2c_target.sv
`timescale 1ns/100ps

// I2C target byte engine
// Turns bus traffic into a register pointer and write/read strobes.
// SDA is driven as an open-drain pull and resolved outside the block.

module i2c_target #(
	parameter logic [6:0] i2c_addr = 7'h40
) (
	input  logic                  sysclk,
	input  logic                  reset,
	input  logic                  scl,
	input  logic                  sda_in,
	output logic                  sda_pull,
	output bp_reg_pkg::reg_addr_t reg_addr,
	output bp_reg_pkg::reg_data_t wr_data,
	output logic                  wr_strobe,
	output logic                  rd_strobe,
	input  bp_reg_pkg::reg_data_t rd_data
);
	import bp_reg_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_dev_addr,
		st_ack,
		st_pointer,
		st_wr_data,
		st_rd_data,
		st_rd_ack
	} state_e;

	state_e     state;
	state_e     ack_next;
	logic [1:0] scl_sync;
	logic [1:0] sda_sync;
	logic       scl_prev;
	logic       sda_prev;
	logic       scl_rise;
	logic       scl_fall;
	logic       start_det;
	logic       stop_det;
	logic       byte_done;
	logic       rx_shift;
	logic       tx_shift;
	logic [3:0] bit_cnt;
	logic [1:0] rd_pend;
	reg_data_t  shift_reg;

	// *********************************************************
	// Bus sampling and event detect
	// *********************************************************

	assign scl_rise  = scl_sync[1] & ~scl_prev;
	assign scl_fall  = ~scl_sync[1] & scl_prev;
	// SDA moving while SCL stays high
	assign start_det = scl_sync[1] & scl_prev & sda_prev & ~sda_sync[1];
	assign stop_det  = scl_sync[1] & scl_prev & ~sda_prev & sda_sync[1];
	assign byte_done = scl_fall && (bit_cnt == 4'd8);

	assign rx_shift = scl_rise &&
		(state == st_dev_addr || state == st_pointer || state == st_wr_data);
	assign tx_shift = scl_fall &&
		(state == st_rd_data || state == st_rd_ack ||
		(state == st_ack && ack_next == st_rd_data));

	// Data path, shared between receive and transmit
	always_ff @(posedge sysclk) begin
		if (rd_pend[1])
			shift_reg <= rd_data;
		else if (rx_shift)
			shift_reg <= {shift_reg[6:0], sda_sync[1]};
		else if (tx_shift)
			shift_reg <= {shift_reg[6:0], 1'b0};

		if (byte_done && state == st_wr_data)
			wr_data <= shift_reg;
	end

	// *********************************************************
	// Protocol FSM
	// *********************************************************

	always_ff @(posedge sysclk) begin
		if (reset) begin
			scl_sync  <= 2'b11;
			sda_sync  <= 2'b11;
			scl_prev  <= 1'b1;
			sda_prev  <= 1'b1;
			state     <= st_idle;
			ack_next  <= st_idle;
			bit_cnt   <= '0;
			sda_pull  <= 1'b0;
			reg_addr  <= '0;
			wr_strobe <= 1'b0;
			rd_strobe <= 1'b0;
			rd_pend   <= '0;
		end else begin
			scl_sync  <= {scl_sync[0], scl};
			sda_sync  <= {sda_sync[0], sda_in};
			scl_prev  <= scl_sync[1];
			sda_prev  <= sda_sync[1];
			wr_strobe <= 1'b0;
			rd_strobe <= 1'b0;
			// Read data is picked up two cycles after the strobe
			rd_pend   <= {rd_pend[0], rd_strobe};

			// Pointer steps once the written byte has been taken
			if (wr_strobe)
				reg_addr <= reg_addr + 8'd1;

			if (start_det) begin
				// Also covers repeated start, pointer is kept
				state    <= st_dev_addr;
				bit_cnt  <= '0;
				sda_pull <= 1'b0;
			end else if (stop_det) begin
				state    <= st_idle;
				sda_pull <= 1'b0;
			end else begin
				case (state)
					st_dev_addr: begin
						if (scl_rise) begin
							bit_cnt <= bit_cnt + 4'd1;
						end else if (byte_done) begin
							bit_cnt <= '0;
							if (shift_reg[7:1] == i2c_addr) begin
								sda_pull <= 1'b1;
								state    <= st_ack;
								if (shift_reg[0]) begin
									ack_next  <= st_rd_data;
									rd_strobe <= 1'b1;
								end else begin
									ack_next <= st_pointer;
								end
							end else begin
								// Someone else's transfer, stay off the bus
								state <= st_idle;
							end
						end
					end
					st_pointer: begin
						if (scl_rise) begin
							bit_cnt <= bit_cnt + 4'd1;
						end else if (byte_done) begin
							bit_cnt  <= '0;
							reg_addr <= shift_reg;
							sda_pull <= 1'b1;
							state    <= st_ack;
							ack_next <= st_wr_data;
						end
					end
					st_wr_data: begin
						if (scl_rise) begin
							bit_cnt <= bit_cnt + 4'd1;
						end else if (byte_done) begin
							bit_cnt   <= '0;
							wr_strobe <= 1'b1;
							sda_pull  <= 1'b1;
							state     <= st_ack;
							ack_next  <= st_wr_data;
						end
					end
					st_ack: begin
						// End of the ACK bit
						if (scl_fall) begin
							state <= ack_next;
							if (ack_next == st_rd_data)
								sda_pull <= ~shift_reg[7];
							else
								sda_pull <= 1'b0;
						end
					end
					st_rd_data: begin
						if (scl_rise) begin
							bit_cnt <= bit_cnt + 4'd1;
						end else if (byte_done) begin
							bit_cnt  <= '0;
							sda_pull <= 1'b0;
							reg_addr <= reg_addr + 8'd1;
							state    <= st_rd_ack;
						end else if (scl_fall) begin
							sda_pull <= ~shift_reg[7];
						end
					end
					st_rd_ack: begin
						if (scl_rise) begin
							// NACK ends the read
							if (sda_sync[1])
								state <= st_idle;
							else
								rd_strobe <= 1'b1;
						end else if (scl_fall) begin
							sda_pull <= ~shift_reg[7];
							state    <= st_rd_data;
						end
					end
					default: begin
						sda_pull <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

//--- src/led_pattern.sv
`timescale 1ns/100ps

// LED pattern generator
// Maps each drive's health and fault mode onto the blink phases and
// registers the LED levels

module led_pattern (
	input  logic                                sysclk,
	input  logic                                reset,
	input  logic [4*bp_reg_pkg::num_drives-1:0] health_modes,
	input  logic [4*bp_reg_pkg::num_drives-1:0] fault_modes,
	input  bp_led_pkg::blink_phase_t            blink_phase,
	output logic [bp_reg_pkg::num_drives-1:0]   health_led,
	output logic [bp_reg_pkg::num_drives-1:0]   fault_led
);
	import bp_reg_pkg::*;
	import bp_led_pkg::*;

	function automatic logic led_level(input logic [3:0] mode, input blink_phase_t phase);
		logic level;
		case (led_mode_e'(mode))
			led_off:       level = 1'b0;
			led_on:        level = 1'b1;
			led_blink_1hz: level = phase[phase_1hz_bit];
			led_blink_2hz: level = phase[phase_2hz_bit];
			led_blink_4hz: level = phase[phase_4hz_bit];
			// Reserved codes stay dark
			default:       level = 1'b0;
		endcase
		return level;
	endfunction

	always_ff @(posedge sysclk) begin
		if (reset) begin
			health_led <= '0;
			fault_led  <= '0;
		end else begin
			for (int i = 0; i < num_drives; i++) begin
				health_led[i] <= led_level(health_modes[4*i +: 4], blink_phase);
				fault_led[i]  <= led_level(fault_modes[4*i +: 4], blink_phase);
			end
		end
	end

endmodule
